// ==== hw/ps2_pkg.sv ====
//==========================================================================
// PS/2 event word layout and the scan codes the keypad emulation knows
// Imported by the keyboard decoder and the top level
//==========================================================================
package ps2_pkg;

        // Event word fields
        localparam int PS2_KEY_W       = 11;
        localparam int PS2_TOGGLE_BIT  = 10;
        localparam int PS2_PRESSED_BIT = 9;
        localparam int PS2_CODE_W      = 9;

        // Main row digits
        localparam logic [7:0] SC_1 = 8'h16;
        localparam logic [7:0] SC_2 = 8'h1E;
        localparam logic [7:0] SC_3 = 8'h26;
        localparam logic [7:0] SC_4 = 8'h25;
        localparam logic [7:0] SC_5 = 8'h2E;
        localparam logic [7:0] SC_6 = 8'h36;
        localparam logic [7:0] SC_7 = 8'h3D;
        localparam logic [7:0] SC_8 = 8'h3E;
        localparam logic [7:0] SC_9 = 8'h46;
        localparam logic [7:0] SC_0 = 8'h45;

        // Numeric pad digits
        localparam logic [7:0] SC_KP1 = 8'h69;
        localparam logic [7:0] SC_KP2 = 8'h72;
        localparam logic [7:0] SC_KP3 = 8'h7A;
        localparam logic [7:0] SC_KP4 = 8'h6B;
        localparam logic [7:0] SC_KP5 = 8'h73;
        localparam logic [7:0] SC_KP6 = 8'h74;
        localparam logic [7:0] SC_KP7 = 8'h6C;
        localparam logic [7:0] SC_KP8 = 8'h75;
        localparam logic [7:0] SC_KP9 = 8'h7D;
        localparam logic [7:0] SC_KP0 = 8'h70;

        // Star, shifts and keypad minus
        localparam logic [7:0] SC_KPSTAR  = 8'h7C;
        localparam logic [7:0] SC_LSHIFT  = 8'h12;
        localparam logic [7:0] SC_RSHIFT  = 8'h59;
        localparam logic [7:0] SC_KPMINUS = 8'h7B;

endpackage

// ==== hw/cv_ctrl_pkg.sv ====
//==========================================================================
// Controller path definitions: keypad indices, joystick bits, line codes
// Imported by every controller module and the testbench
//==========================================================================
package cv_ctrl_pkg;

        localparam int JOY_W    = 32;
        localparam int KEYPAD_N = 20;

        // Keypad vector indices
        localparam int KP_DIGIT0 = 0;
        localparam int KP_DIGIT1 = 1;
        localparam int KP_DIGIT2 = 2;
        localparam int KP_DIGIT3 = 3;
        localparam int KP_DIGIT4 = 4;
        localparam int KP_DIGIT5 = 5;
        localparam int KP_DIGIT6 = 6;
        localparam int KP_DIGIT7 = 7;
        localparam int KP_DIGIT8 = 8;
        localparam int KP_DIGIT9 = 9;
        localparam int KP_STAR   = 10;
        localparam int KP_HASH   = 11;
        localparam int KP_PURPLE = 12;
        localparam int KP_BLUE   = 13;
        localparam int KP_UP     = 14;
        localparam int KP_DOWN   = 15;
        localparam int KP_LEFT   = 16;
        localparam int KP_RIGHT  = 17;
        localparam int KP_FIRE_L = 18;
        localparam int KP_FIRE_R = 19;

        // Host joystick word bit positions
        localparam int JOY_RIGHT      = 0;
        localparam int JOY_LEFT       = 1;
        localparam int JOY_DOWN       = 2;
        localparam int JOY_UP         = 3;
        localparam int JOY_FIRE_L     = 4;
        localparam int JOY_FIRE_R     = 5;
        localparam int JOY_STAR       = 6;
        localparam int JOY_HASH       = 7;
        localparam int JOY_DIGIT_BASE = 8;
        localparam int JOY_PURPLE     = 18;
        localparam int JOY_BLUE       = 19;

        typedef logic [KEYPAD_N-1:0] keypad_t;
        typedef logic [3:0]          ctrl_lines_t;

        // Keypad line codes, active low
        localparam ctrl_lines_t CODE_KEY0   = 4'b0011;
        localparam ctrl_lines_t CODE_KEY1   = 4'b1110;
        localparam ctrl_lines_t CODE_KEY2   = 4'b1101;
        localparam ctrl_lines_t CODE_KEY3   = 4'b0110;
        localparam ctrl_lines_t CODE_KEY4   = 4'b0001;
        localparam ctrl_lines_t CODE_KEY5   = 4'b1001;
        localparam ctrl_lines_t CODE_KEY6   = 4'b0111;
        localparam ctrl_lines_t CODE_KEY7   = 4'b1100;
        localparam ctrl_lines_t CODE_KEY8   = 4'b1000;
        localparam ctrl_lines_t CODE_KEY9   = 4'b1011;
        localparam ctrl_lines_t CODE_STAR   = 4'b1010;
        localparam ctrl_lines_t CODE_HASH   = 4'b0101;
        localparam ctrl_lines_t CODE_PURPLE = 4'b0100;
        localparam ctrl_lines_t CODE_BLUE   = 4'b0010;
        localparam ctrl_lines_t CODE_NONE   = 4'b1111;

        // Buttons held on the PS/2 keyboard
        typedef struct packed {
                logic [9:0] digit;
                logic       star;
                logic       hash;
        } kbd_keys_t;

endpackage

// ==== hw/keypad_if.sv ====
//==========================================================================
// One player's keypad vector, driven by the merge and read by an encoder
//==========================================================================
`timescale 1ns/1ps

interface keypad_if import cv_ctrl_pkg::*; ();

        // Level only, no handshake
        keypad_t keys;

        modport source (
                output keys
        );

        modport sink (
                input keys
        );

endinterface

// ==== hw/kbd_keypad_decoder.sv ====
//==========================================================================
// Keypad emulation from PS/2 keyboard events
// Each toggle of the event word updates one held button
//==========================================================================
`timescale 1ns/1ps

module kbd_keypad_decoder import ps2_pkg::*, cv_ctrl_pkg::*; (
        input  logic                 clk_sys,
        input  logic                 rst_n_i,
        input  logic [PS2_KEY_W-1:0] ps2_key_i,
        output kbd_keys_t            kbd_keys_o
);

        logic [PS2_CODE_W-1:0] code;
        logic                  pressed;
        logic                  toggle;
        logic                  toggle_q;
        logic                  event_seen;
        logic [9:0]            digit_q;
        logic                  star_q;
        logic                  minus_q;
        logic                  shift_q;

        assign code       = ps2_key_i[PS2_CODE_W-1:0];
        assign pressed    = ps2_key_i[PS2_PRESSED_BIT];
        assign toggle     = ps2_key_i[PS2_TOGGLE_BIT];
        assign event_seen = toggle != toggle_q;

        always_ff @(posedge clk_sys) begin
                if (!rst_n_i) begin
                        toggle_q <= 1'b0;
                end else begin
                        toggle_q <= toggle;
                end
        end

        //==================================================================
        // Button registers
        //==================================================================

        // Extended prefix bit 8 is not looked at
        always_ff @(posedge clk_sys) begin
                if (!rst_n_i) begin
                        digit_q <= '0;
                        star_q  <= 1'b0;
                        minus_q <= 1'b0;
                        shift_q <= 1'b0;
                end else if (event_seen) begin
                        case (code[7:0])
                                SC_0, SC_KP0: digit_q[0] <= pressed;
                                SC_1, SC_KP1: digit_q[1] <= pressed;
                                SC_2, SC_KP2: digit_q[2] <= pressed;
                                SC_3, SC_KP3: digit_q[3] <= pressed;
                                SC_4, SC_KP4: digit_q[4] <= pressed;
                                SC_5, SC_KP5: digit_q[5] <= pressed;
                                SC_6, SC_KP6: digit_q[6] <= pressed;
                                SC_7, SC_KP7: digit_q[7] <= pressed;
                                SC_8, SC_KP8: digit_q[8] <= pressed;
                                SC_9, SC_KP9: digit_q[9] <= pressed;
                                SC_KPSTAR:    star_q     <= pressed;
                                SC_KPMINUS:   minus_q    <= pressed;
                                // Both shift keys share one register
                                SC_LSHIFT, SC_RSHIFT: shift_q <= pressed;
                                default: ;
                        endcase
                end
        end

        //==================================================================
        // Button outputs
        //==================================================================

        // Shift+8 gives star and shift+3 gives hash
        assign kbd_keys_o.digit = digit_q;
        assign kbd_keys_o.star  = star_q | (shift_q & digit_q[8]);
        assign kbd_keys_o.hash  = minus_q | (shift_q & digit_q[3]);

endmodule

// ==== hw/joy_keypad_merge.sv ====
//==========================================================================
// Joystick swap and remap into keypad vectors, keyboard buttons merged in
//==========================================================================
`timescale 1ns/1ps

module joy_keypad_merge import cv_ctrl_pkg::*; (
        input  logic [JOY_W-1:0] joy0_i,
        input  logic [JOY_W-1:0] joy1_i,
        input  logic             swap_i,
        input  kbd_keys_t        kbd_keys_i,
        keypad_if.source         kp0,
        keypad_if.source         kp1
);

        logic [JOY_W-1:0] joy_a;
        logic [JOY_W-1:0] joy_b;
        keypad_t          kbd_vec;

        // Host joystick word to keypad vector
        function automatic keypad_t map_joy(input logic [JOY_W-1:0] joy);
                keypad_t kp;
                for (int d = 0; d <= KP_DIGIT9 - KP_DIGIT0; d++) begin
                        kp[KP_DIGIT0 + d] = joy[JOY_DIGIT_BASE + d];
                end
                kp[KP_STAR]   = joy[JOY_STAR];
                kp[KP_HASH]   = joy[JOY_HASH];
                kp[KP_PURPLE] = joy[JOY_PURPLE];
                kp[KP_BLUE]   = joy[JOY_BLUE];
                kp[KP_UP]     = joy[JOY_UP];
                kp[KP_DOWN]   = joy[JOY_DOWN];
                kp[KP_LEFT]   = joy[JOY_LEFT];
                kp[KP_RIGHT]  = joy[JOY_RIGHT];
                kp[KP_FIRE_L] = joy[JOY_FIRE_L];
                kp[KP_FIRE_R] = joy[JOY_FIRE_R];
                return kp;
        endfunction

        // Player swap
        assign joy_a = swap_i ? joy1_i : joy0_i;
        assign joy_b = swap_i ? joy0_i : joy1_i;

        // Keyboard covers digits, star and hash only
        always_comb begin
                kbd_vec = '0;
                kbd_vec[KP_DIGIT9:KP_DIGIT0] = kbd_keys_i.digit;
                kbd_vec[KP_STAR]             = kbd_keys_i.star;
                kbd_vec[KP_HASH]             = kbd_keys_i.hash;
        end

        // The keyboard acts on both players
        assign kp0.keys = map_joy(joy_a) | kbd_vec;
        assign kp1.keys = map_joy(joy_b) | kbd_vec;

endmodule

// ==== hw/ctrl_port_encoder.sv ====
//==========================================================================
// One controller port: keypad vector onto the lines under the two strobes
//==========================================================================
`timescale 1ns/1ps

module ctrl_port_encoder import cv_ctrl_pkg::*; (
        keypad_if.sink      kp_i,
        input  logic        kp_strobe_n_i,
        input  logic        joy_strobe_n_i,
        output ctrl_lines_t lines_o,
        output logic        fire_n_o
);

        ctrl_lines_t kp_code;
        ctrl_lines_t kp_part;
        ctrl_lines_t joy_part;
        logic        kp_fire_n;
        logic        joy_fire_n;

        function automatic ctrl_lines_t code_of(input int idx);
                case (idx)
                        KP_DIGIT0: return CODE_KEY0;
                        KP_DIGIT1: return CODE_KEY1;
                        KP_DIGIT2: return CODE_KEY2;
                        KP_DIGIT3: return CODE_KEY3;
                        KP_DIGIT4: return CODE_KEY4;
                        KP_DIGIT5: return CODE_KEY5;
                        KP_DIGIT6: return CODE_KEY6;
                        KP_DIGIT7: return CODE_KEY7;
                        KP_DIGIT8: return CODE_KEY8;
                        KP_DIGIT9: return CODE_KEY9;
                        KP_STAR:   return CODE_STAR;
                        KP_HASH:   return CODE_HASH;
                        KP_PURPLE: return CODE_PURPLE;
                        KP_BLUE:   return CODE_BLUE;
                        default:   return CODE_NONE;
                endcase
        endfunction

        // Lowest set index wins, scanned from blue down
        always_comb begin
                kp_code = CODE_NONE;
                for (int i = KP_BLUE; i >= KP_DIGIT0; i--) begin
                        if (kp_i.keys[i]) begin
                                kp_code = code_of(i);
                        end
                end
        end

        //==================================================================
        // Strobe selection
        //==================================================================

        // Keypad half, right fire
        assign kp_part   = kp_strobe_n_i ? CODE_NONE : kp_code;
        assign kp_fire_n = kp_strobe_n_i | ~kp_i.keys[KP_FIRE_R];

        // Joystick half, directions as bits 3 to 0, left fire
        assign joy_part   = joy_strobe_n_i ? 4'b1111 :
                            ~{kp_i.keys[KP_UP], kp_i.keys[KP_DOWN],
                              kp_i.keys[KP_LEFT], kp_i.keys[KP_RIGHT]};
        assign joy_fire_n = joy_strobe_n_i | ~kp_i.keys[KP_FIRE_L];

        // Active-low lines, so both halves combine by AND
        assign lines_o  = kp_part & joy_part;
        assign fire_n_o = kp_fire_n & joy_fire_n;

endmodule

// ==== hw/cv_ctrl_top.sv ====
//==========================================================================
// Controller input path top level
// PS/2 and joystick inputs in, two controller ports out
//==========================================================================
`timescale 1ns/1ps

module cv_ctrl_top import ps2_pkg::*, cv_ctrl_pkg::*; (
        input  logic                 clk_sys,
        input  logic                 rst_n_i,
        input  logic [PS2_KEY_W-1:0] ps2_key_i,
        input  logic [JOY_W-1:0]     joy0_i,
        input  logic [JOY_W-1:0]     joy1_i,
        input  logic                 swap_i,
        input  logic [1:0]           kp_strobe_n_i,
        input  logic [1:0]           joy_strobe_n_i,
        output ctrl_lines_t          ctrl0_lines_o,
        output ctrl_lines_t          ctrl1_lines_o,
        output logic                 fire0_n_o,
        output logic                 fire1_n_o
);

        kbd_keys_t kbd_keys;

        // One keypad vector per player
        keypad_if kp_if0 ();
        keypad_if kp_if1 ();

        kbd_keypad_decoder kbd_keypad_decoder_inst (
                .clk_sys    (clk_sys),
                .rst_n_i    (rst_n_i),
                .ps2_key_i  (ps2_key_i),
                .kbd_keys_o (kbd_keys)
        );

        joy_keypad_merge joy_keypad_merge_inst (
                .joy0_i     (joy0_i),
                .joy1_i     (joy1_i),
                .swap_i     (swap_i),
                .kbd_keys_i (kbd_keys),
                .kp0        (kp_if0.source),
                .kp1        (kp_if1.source)
        );

        //==================================================================
        // Port encoders, strobe bit n serves port n
        //==================================================================

        ctrl_port_encoder enc0 (
                .kp_i           (kp_if0.sink),
                .kp_strobe_n_i  (kp_strobe_n_i[0]),
                .joy_strobe_n_i (joy_strobe_n_i[0]),
                .lines_o        (ctrl0_lines_o),
                .fire_n_o       (fire0_n_o)
        );

        ctrl_port_encoder enc1 (
                .kp_i           (kp_if1.sink),
                .kp_strobe_n_i  (kp_strobe_n_i[1]),
                .joy_strobe_n_i (joy_strobe_n_i[1]),
                .lines_o        (ctrl1_lines_o),
                .fire_n_o       (fire1_n_o)
        );

endmodule

// ==== verif/tb_cv_ctrl.sv ====
//==========================================================================
// Testbench for the controller input path: random joysticks, strobes and
// PS/2 events from a fixed seed, checked against a model kept in here
//==========================================================================
`timescale 1ns/1ps

module tb_cv_ctrl import ps2_pkg::*, cv_ctrl_pkg::*; ();

        logic                 clk_sys = 1'b0;
        logic                 rst_n_i;
        logic [PS2_KEY_W-1:0] ps2_key;
        logic [JOY_W-1:0]     joy0;
        logic [JOY_W-1:0]     joy1;
        logic                 swap;
        logic [1:0]           kp_strobe_n;
        logic [1:0]           joy_strobe_n;
        ctrl_lines_t          ctrl0_lines;
        ctrl_lines_t          ctrl1_lines;
        logic                 fire0_n;
        logic                 fire1_n;

        int seed;
        int n_checks;
        int n_errors;

        // Model of the held keyboard buttons
        logic [9:0] m_digit;
        logic       m_star;
        logic       m_minus;
        logic       m_shift;

        // Line codes for keypad indices 0 to 13, from the reference table
        ctrl_lines_t key_codes [14] = '{
                4'b0011, 4'b1110, 4'b1101, 4'b0110, 4'b0001, 4'b1001, 4'b0111,
                4'b1100, 4'b1000, 4'b1011, 4'b1010, 4'b0101, 4'b0100, 4'b0010
        };

        // Codes the random events pick from, two unlisted ones at the end
        logic [7:0] key_pool [26] = '{
                SC_0, SC_1, SC_2, SC_3, SC_4, SC_5, SC_6, SC_7, SC_8, SC_9,
                SC_KP0, SC_KP1, SC_KP2, SC_KP3, SC_KP4,
                SC_KP5, SC_KP6, SC_KP7, SC_KP8, SC_KP9,
                SC_KPSTAR, SC_KPMINUS, SC_LSHIFT, SC_RSHIFT,
                8'h1C, 8'h29
        };

        always #4 clk_sys = ~clk_sys;

        cv_ctrl_top cv_ctrl_top_inst (
                .clk_sys        (clk_sys),
                .rst_n_i        (rst_n_i),
                .ps2_key_i      (ps2_key),
                .joy0_i         (joy0),
                .joy1_i         (joy1),
                .swap_i         (swap),
                .kp_strobe_n_i  (kp_strobe_n),
                .joy_strobe_n_i (joy_strobe_n),
                .ctrl0_lines_o  (ctrl0_lines),
                .ctrl1_lines_o  (ctrl1_lines),
                .fire0_n_o      (fire0_n),
                .fire1_n_o      (fire1_n)
        );

        //==================================================================
        // Reference model
        //==================================================================

        // Joystick word to keypad vector, bit by bit from the table
        function automatic keypad_t joy_to_keypad(input logic [JOY_W-1:0] joy);
                keypad_t kp;
                kp = '0;
                kp[9:0] = joy[17:8];
                kp[10]  = joy[6];
                kp[11]  = joy[7];
                kp[12]  = joy[18];
                kp[13]  = joy[19];
                kp[14]  = joy[3];
                kp[15]  = joy[2];
                kp[16]  = joy[1];
                kp[17]  = joy[0];
                kp[18]  = joy[4];
                kp[19]  = joy[5];
                return kp;
        endfunction

        // Keyboard part, shift+8 is star and shift+3 is hash
        function automatic keypad_t model_kbd_vec();
                keypad_t kp;
                kp = '0;
                kp[9:0]     = m_digit;
                kp[KP_STAR] = m_star | (m_shift & m_digit[8]);
                kp[KP_HASH] = m_minus | (m_shift & m_digit[3]);
                return kp;
        endfunction

        function automatic ctrl_lines_t lowest_key_code(input keypad_t kp);
                for (int i = 0; i < 14; i++) begin
                        if (kp[i]) begin
                                return key_codes[i];
                        end
                end
                return 4'b1111;
        endfunction

        // Expected {lines, fire_n} of one port
        function automatic logic [4:0] expected_port(input keypad_t kp,
                                                     input logic kp_stb_n,
                                                     input logic joy_stb_n);
                ctrl_lines_t kp_part;
                ctrl_lines_t joy_part;
                logic        kp_fire;
                logic        joy_fire;
                kp_part  = kp_stb_n ? 4'b1111 : lowest_key_code(kp);
                kp_fire  = kp_stb_n ? 1'b1 : ~kp[KP_FIRE_R];
                joy_part = joy_stb_n ? 4'b1111 : ~{kp[14], kp[15], kp[16], kp[17]};
                joy_fire = joy_stb_n ? 1'b1 : ~kp[KP_FIRE_L];
                return {kp_part & joy_part, kp_fire & joy_fire};
        endfunction

        task automatic update_model(input logic [7:0] code, input logic pressed);
                case (code)
                        SC_0, SC_KP0:         m_digit[0] = pressed;
                        SC_1, SC_KP1:         m_digit[1] = pressed;
                        SC_2, SC_KP2:         m_digit[2] = pressed;
                        SC_3, SC_KP3:         m_digit[3] = pressed;
                        SC_4, SC_KP4:         m_digit[4] = pressed;
                        SC_5, SC_KP5:         m_digit[5] = pressed;
                        SC_6, SC_KP6:         m_digit[6] = pressed;
                        SC_7, SC_KP7:         m_digit[7] = pressed;
                        SC_8, SC_KP8:         m_digit[8] = pressed;
                        SC_9, SC_KP9:         m_digit[9] = pressed;
                        SC_KPSTAR:            m_star     = pressed;
                        SC_KPMINUS:           m_minus    = pressed;
                        SC_LSHIFT, SC_RSHIFT: m_shift    = pressed;
                        default: ;
                endcase
        endtask

        //==================================================================
        // Checks and stimulus helpers
        //==================================================================

        task automatic compare_port(input string what, input int port,
                                    input ctrl_lines_t lines, input logic fire_n,
                                    input logic [4:0] exp);
                n_checks++;
                assert ({lines, fire_n} == exp) else begin
                        $display("ERROR at %0t: %s, port %0d lines %b fire %b", $time, what,
                                 port, lines, fire_n);
                        $display("      expected lines %b fire %b", exp[4:1], exp[0]);
                        n_errors++;
                end
        endtask

        task automatic check_ports(input string what);
                keypad_t kp0;
                keypad_t kp1;
                kp0 = joy_to_keypad(swap ? joy1 : joy0) | model_kbd_vec();
                kp1 = joy_to_keypad(swap ? joy0 : joy1) | model_kbd_vec();
                compare_port(what, 0, ctrl0_lines, fire0_n,
                             expected_port(kp0, kp_strobe_n[0], joy_strobe_n[0]));
                compare_port(what, 1, ctrl1_lines, fire1_n,
                             expected_port(kp1, kp_strobe_n[1], joy_strobe_n[1]));
        endtask

        task automatic wait_idle(input int max_cycles);
                int  n;
                logic idle;
                n    = 0;
                idle = 1'b0;
                while (!idle && n < max_cycles) begin
                        @(posedge clk_sys);
                        idle = ctrl0_lines == 4'b1111 && ctrl1_lines == 4'b1111 &&
                               fire0_n && fire1_n;
                        n++;
                end
                if (!idle) begin
                        $display("Timeout: controller ports did not go idle after reset");
                        n_errors++;
                end
        endtask

        // One PS/2 event, checked while held and again once registered
        // Then its pressed bit flips with the toggle left alone
        task automatic send_event(input logic [7:0] code, input logic pressed,
                                  input logic ext);
                @(posedge clk_sys);
                ps2_key <= {~ps2_key[PS2_TOGGLE_BIT], pressed, ext, code};
                #7;
                check_ports("key event held");
                @(posedge clk_sys);
                update_model(code, pressed);
                #7;
                check_ports("key event applied");
                // Same toggle value, so no new event
                @(posedge clk_sys);
                ps2_key[PS2_PRESSED_BIT] <= ~pressed;
                @(posedge clk_sys);
                #7;
                check_ports("fields changed without toggle");
        endtask

        //==================================================================
        // Test sequence
        //==================================================================

        initial begin
                int         r;
                int         idx;
                logic [7:0] code;

                seed         = 32'h89b;
                n_checks     = 0;
                n_errors     = 0;
                rst_n_i      = 1'b0;
                ps2_key      = '0;
                joy0         = '0;
                joy1         = '0;
                swap         = 1'b0;
                kp_strobe_n  = 2'b11;
                joy_strobe_n = 2'b11;
                m_digit      = '0;
                m_star       = 1'b0;
                m_minus      = 1'b0;
                m_shift      = 1'b0;

                repeat (3) @(posedge clk_sys);
                rst_n_i <= 1'b1;
                wait_idle(16);

                @(posedge clk_sys);
                #7;
                check_ports("reset, strobes high");
                @(posedge clk_sys);
                kp_strobe_n <= 2'b00;
                #7;
                check_ports("reset, keypad strobes low");

                // Keypad priority, dense and sparse joystick words
                for (int i = 0; i < 200; i++) begin
                        @(posedge clk_sys);
                        if (i % 3 == 0) begin
                                joy0 <= $random(seed);
                                joy1 <= $random(seed);
                        end else if (i % 3 == 1) begin
                                joy0 <= $random(seed) & $random(seed) & $random(seed);
                                joy1 <= $random(seed) & $random(seed) & $random(seed);
                        end else begin
                                joy0 <= $random(seed) & $random(seed) & $random(seed)
                                        & $random(seed) & $random(seed);
                                joy1 <= $random(seed) & $random(seed) & $random(seed)
                                        & $random(seed) & $random(seed);
                        end
                        #7;
                        check_ports("keypad priority");
                end

                // Directions and fire under every strobe mix
                for (int i = 0; i < 200; i++) begin
                        @(posedge clk_sys);
                        r = $random(seed);
                        joy0         <= $random(seed);
                        joy1         <= $random(seed);
                        kp_strobe_n  <= r[1:0];
                        joy_strobe_n <= r[3:2];
                        #7;
                        check_ports("directions and fire");
                end

                // Swap flips every cycle, words change every other one
                for (int i = 0; i < 100; i++) begin
                        @(posedge clk_sys);
                        r = $random(seed);
                        if (i % 2 == 0) begin
                                joy0 <= $random(seed);
                                joy1 <= $random(seed);
                        end
                        swap         <= ~swap;
                        kp_strobe_n  <= r[1:0];
                        joy_strobe_n <= r[3:2];
                        #7;
                        check_ports("swap");
                end

                @(posedge clk_sys);
                joy0         <= '0;
                joy1         <= '0;
                swap         <= 1'b0;
                kp_strobe_n  <= 2'b00;
                joy_strobe_n <= 2'b11;

                // Directed keyboard events, shift combinations first
                send_event(SC_KP8, 1'b1, 1'b0);
                send_event(SC_LSHIFT, 1'b1, 1'b0);
                send_event(SC_KP8, 1'b0, 1'b0);
                send_event(SC_3, 1'b1, 1'b0);
                send_event(SC_LSHIFT, 1'b0, 1'b0);
                send_event(SC_RSHIFT, 1'b1, 1'b0);
                send_event(SC_8, 1'b1, 1'b0);
                send_event(SC_RSHIFT, 1'b0, 1'b0);
                send_event(SC_8, 1'b0, 1'b0);
                send_event(SC_3, 1'b0, 1'b0);
                // Extended prefix set, still a keypad minus
                send_event(SC_KPMINUS, 1'b1, 1'b1);
                send_event(SC_KPSTAR, 1'b1, 1'b0);
                send_event(SC_KPMINUS, 1'b0, 1'b0);
                send_event(SC_KPSTAR, 1'b0, 1'b0);
                send_event(8'h1C, 1'b1, 1'b0);

                // Random events, now and then a code from anywhere
                for (int i = 0; i < 300; i++) begin
                        r = $random(seed);
                        if (r[3:0] == 4'd0) begin
                                code = r[15:8];
                        end else begin
                                idx  = r[15:8] % 26;
                                code = key_pool[idx];
                        end
                        send_event(code, r[16], r[17]);
                end

                $display("Checks: %0d, errors: %0d", n_checks, n_errors);
                if (n_errors == 0) begin
                        $display("PASS: all tests");
                end else begin
                        $display("FAIL: see errors above");
                end
                $finish;
        end

        // Watchdog for the whole run
        initial begin
                #1_000_000;
                $display("Timeout: the test did not finish within 1 ms of simulated time");
                $display("FAIL: see errors above");
                $finish;
        end

endmodule

// ==== vlog.f ====
hw/ps2_pkg.sv
hw/cv_ctrl_pkg.sv
hw/keypad_if.sv
hw/kbd_keypad_decoder.sv
hw/joy_keypad_merge.sv
hw/ctrl_port_encoder.sv
hw/cv_ctrl_top.sv
verif/tb_cv_ctrl.sv

// ==== Makefile ====
SIM      = verilator
TOP      = tb_cv_ctrl
FILELIST = vlog.f
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
PASS_MSG = PASS: all tests
SRCS     = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
